// ==== xbar_defs.svh ====
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// Size of the stream crossbar.
// The core, the top level and the package all read their dimensions from here.

// Number of input streams.
// Each input can reach every output.
`define XBAR_NUM_INP 4

// Number of output streams.
// Each output owns one arbiter and one spill register.
`define XBAR_NUM_OUT 4

// Width of the data word carried by every stream.
`define XBAR_DATA_WIDTH 16

`endif

// ==== xbar_pkg.sv ====
`include "xbar_defs.svh"

// Types shared by all modules of the stream crossbar.
package xbar_pkg;

  // Width of the output select.
  // A single output still needs one select bit.
  localparam int unsigned SEL_WIDTH = (`XBAR_NUM_OUT > 1) ? $clog2(`XBAR_NUM_OUT) : 1;

  // Width of the input index.
  // It is sized the same way from the input count.
  localparam int unsigned IDX_WIDTH = (`XBAR_NUM_INP > 1) ? $clog2(`XBAR_NUM_INP) : 1;

  // Data word that travels from an input to an output.
  typedef logic [`XBAR_DATA_WIDTH-1:0] payload_t;

  // Output select that comes with each input word.
  typedef logic [SEL_WIDTH-1:0] sel_t;

  // Index of the input a delivered word came from.
  typedef logic [IDX_WIDTH-1:0] idx_t;

endpackage

// ==== stream_if.sv ====
`timescale 1ns/1ps

// Valid/ready stream carrying a data word and its source input index.
// Inside the crossbar this joins an output arbiter to its spill register.
// The handshake is strict: once valid rises, valid, data and idx hold
// until the edge where ready is also high.
interface stream_if #(
  parameter type T = logic
) ();

  // Source has an item on the bus.
  logic           valid;
  // Sink accepts the item on this edge.
  logic           ready;
  // Payload word.
  T               data;
  // Input the payload was taken from.
  xbar_pkg::idx_t idx;

  // Side that produces items.
  modport src (
    output valid, data, idx,
    input  ready
  );

  // Side that consumes items.
  // This is the mirror of the source modport.
  modport dst (
    input  valid, data, idx,
    output ready
  );

endinterface

// ==== stream_demux.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

// Valid/ready demultiplexer for one crossbar input.
// The select picks exactly one output. That output sees the valid, and the
// input sees that output's ready. The data word is not routed here because
// the core broadcasts it to every arbiter.
// The block is purely combinational.
module stream_demux (
  input  logic                     inp_valid_i,
  output logic                     inp_ready_o,
  input  xbar_pkg::sel_t           sel_i,
  output logic [`XBAR_NUM_OUT-1:0] oup_valid_o,
  input  logic [`XBAR_NUM_OUT-1:0] oup_ready_i
);

  // One-hot valid toward the outputs.
  // Only the selected output sees a request, all others stay low.
  always_comb begin : proc_valid_decode
    oup_valid_o = '0;
    oup_valid_o[sel_i] = inp_valid_i;
  end

  // The ready of the selected output goes back to the input.
  // Since the select holds while valid is high, this stays tied to the
  // same arbiter for the whole handshake.
  assign inp_ready_o = oup_ready_i[sel_i];

endmodule

// ==== rr_arb.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

// Round-robin arbiter with lock-in for one crossbar output.
// Every input raises a request toward this output through its demux.
// The arbiter picks one requester and puts its data word and index on
// the outgoing stream. The grant back to that input follows the stream
// ready combinationally.
// A choice that is offered but not yet accepted stays locked, so the
// outgoing stream obeys the strict handshake even if other inputs raise
// requests in the meantime.
module rr_arb #(
  parameter type T = logic
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic [`XBAR_NUM_INP-1:0] req_i,
  output logic [`XBAR_NUM_INP-1:0] gnt_o,
  input  T     [`XBAR_NUM_INP-1:0] data_i,
  stream_if.src                    oup
);

  // Input where the next search starts.
  xbar_pkg::idx_t ptr_q;
  // Pointer value after a transfer from the current winner.
  xbar_pkg::idx_t ptr_d;
  // Set while an offered item waits for the downstream ready.
  logic           lock_q;
  // Input that holds the lock.
  xbar_pkg::idx_t lock_idx_q;
  // First requester found from the pointer onward.
  xbar_pkg::idx_t search_idx;
  // Input that drives the stream in this cycle.
  xbar_pkg::idx_t win_idx;
  // At least one input requests this output.
  logic           any_req;

  assign any_req = |req_i;

  // Search from the pointer upward and wrap at the last input.
  // The first input that requests wins.
  // With no request at all the result is the pointer itself, which is
  // harmless because the stream valid is low then.
  always_comb begin : proc_search
    int unsigned cand;
    logic        found;
    search_idx = ptr_q;
    found = 1'b0;
    for (int unsigned off = 0; off < `XBAR_NUM_INP; off++) begin
      cand = ptr_q + off;
      if (cand >= `XBAR_NUM_INP) begin
        cand = cand - `XBAR_NUM_INP;
      end
      if (!found && req_i[cand]) begin
        found = 1'b1;
        search_idx = xbar_pkg::idx_t'(cand);
      end
    end
  end

  // A locked choice overrides the search.
  // The locked input keeps its request up until it is granted.
  assign win_idx = lock_q ? lock_idx_q : search_idx;

  // Stream side.
  // Valid only looks at the requests, never at ready.
  assign oup.valid = any_req;
  assign oup.data  = data_i[win_idx];
  assign oup.idx   = win_idx;

  // Only the winner is granted, and only when the stream takes the item.
  always_comb begin : proc_grant
    gnt_o = '0;
    gnt_o[win_idx] = req_i[win_idx] & oup.ready;
  end

  // After a transfer the input just served gets the lowest priority.
  always_comb begin : proc_next_ptr
    if (int'(win_idx) == `XBAR_NUM_INP - 1) begin
      ptr_d = '0;
    end else begin
      ptr_d = win_idx + xbar_pkg::idx_t'(1);
    end
  end

  // Pointer and lock state.
  // A transfer moves the pointer past the winner and releases the lock.
  // An offer without ready locks the current winner, and a held lock just
  // writes the same index again.
  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_state
    if (!arst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (oup.valid && oup.ready) begin
        ptr_q  <= ptr_d;
        lock_q <= 1'b0;
      end else if (oup.valid) begin
        lock_q     <= 1'b1;
        lock_idx_q <= win_idx;
      end
    end
  end

endmodule

// ==== spill_register.sv ====
`timescale 1ns/1ps

// Two-entry output stage of a crossbar output.
// Slot A always holds the oldest item and drives the output.
// Slot B only fills when a new item arrives while A is still waiting for
// the downstream ready. The input ready is the inverse of the B flag, so
// it comes straight from a flop and the ready path from the output back
// into the arbiter is cut.
// Items leave in the order they arrived.
module spill_register #(
  parameter type T = logic
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  stream_if.dst          inp,
  output logic           oup_valid_o,
  input  logic           oup_ready_i,
  output T               oup_data_o,
  output xbar_pkg::idx_t oup_idx_o
);

  // Slot A, the head of the stage.
  logic           a_full_q;
  T               a_data_q;
  xbar_pkg::idx_t a_idx_q;

  // Slot B, the overflow slot. It is only full while A is full too.
  logic           b_full_q;
  T               b_data_q;
  xbar_pkg::idx_t b_idx_q;

  // Handshakes on both sides in this cycle.
  logic           in_fire;
  logic           out_fire;

  // Load strobes for the two slots.
  logic           a_load;
  logic           a_from_b;
  logic           b_load;

  // Space is left while B is empty, which means fewer than two items.
  assign inp.ready = ~b_full_q;

  assign in_fire  = inp.valid & ~b_full_q;
  assign out_fire = a_full_q & oup_ready_i;

  // A takes the item from B when the head leaves and B has one.
  // Otherwise A takes the incoming item when A is empty or leaving.
  assign a_from_b = out_fire & b_full_q;
  assign a_load   = a_from_b | (in_fire & (~a_full_q | out_fire));
  // B only catches an item that finds A full and stalled.
  assign b_load   = in_fire & a_full_q & ~out_fire;

  // Occupancy flags.
  always_ff @(posedge clk_i or negedge arst_n_i) begin : proc_flags
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (out_fire) begin
        a_full_q <= b_full_q | in_fire;
        b_full_q <= 1'b0;
      end else begin
        a_full_q <= a_full_q | in_fire;
        b_full_q <= b_full_q | b_load;
      end
    end
  end

  // Slot contents.
  always_ff @(posedge clk_i) begin : proc_slots
    if (a_load) begin
      a_data_q <= a_from_b ? b_data_q : inp.data;
      a_idx_q  <= a_from_b ? b_idx_q : inp.idx;
    end
    if (b_load) begin
      b_data_q <= inp.data;
      b_idx_q  <= inp.idx;
    end
  end

  // The output is always the head slot.
  assign oup_valid_o = a_full_q;
  assign oup_data_o  = a_data_q;
  assign oup_idx_o   = a_idx_q;

endmodule

// ==== stream_xbar.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

// Fully connected valid/ready stream crossbar.
// Each input names one output through its select. A demux per input turns
// that into a request toward one output. Each output runs a round-robin
// arbiter over all inputs and feeds a two-entry spill register, so every
// output is registered.
// Each delivered word comes with the index of the input it came from.
module stream_xbar (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  xbar_pkg::payload_t [`XBAR_NUM_INP-1:0] data_i,
  input  xbar_pkg::sel_t     [`XBAR_NUM_INP-1:0] sel_i,
  input  logic               [`XBAR_NUM_INP-1:0] valid_i,
  output logic               [`XBAR_NUM_INP-1:0] ready_o,
  output xbar_pkg::payload_t [`XBAR_NUM_OUT-1:0] data_o,
  output xbar_pkg::idx_t     [`XBAR_NUM_OUT-1:0] idx_o,
  output logic               [`XBAR_NUM_OUT-1:0] valid_o,
  input  logic               [`XBAR_NUM_OUT-1:0] ready_i
);

  // Request and grant matrix as seen from the inputs.
  // Index order is [input][output].
  logic [`XBAR_NUM_INP-1:0][`XBAR_NUM_OUT-1:0] inp_valid;
  logic [`XBAR_NUM_INP-1:0][`XBAR_NUM_OUT-1:0] inp_ready;

  // The same matrix as seen from the outputs.
  // Index order is [output][input].
  logic [`XBAR_NUM_OUT-1:0][`XBAR_NUM_INP-1:0] out_valid;
  logic [`XBAR_NUM_OUT-1:0][`XBAR_NUM_INP-1:0] out_ready;

  // One demux per input.
  for (genvar i = 0; i < `XBAR_NUM_INP; i++) begin : gen_inps
    stream_demux i_stream_demux (
      .inp_valid_i ( valid_i[i]   ),
      .inp_ready_o ( ready_o[i]   ),
      .sel_i       ( sel_i[i]     ),
      .oup_valid_o ( inp_valid[i] ),
      .oup_ready_i ( inp_ready[i] )
    );

    // Transpose the handshake between the input view and the output view.
    for (genvar j = 0; j < `XBAR_NUM_OUT; j++) begin : gen_cross
      assign out_valid[j][i] = inp_valid[i][j];
      assign inp_ready[i][j] = out_ready[j][i];
    end
  end

  // One arbiter and one spill register per output.
  for (genvar j = 0; j < `XBAR_NUM_OUT; j++) begin : gen_outs
    // Stream from the arbiter into the spill register.
    stream_if #(.T(xbar_pkg::payload_t)) arb_if ();

    // Every arbiter sees the data words of all inputs.
    rr_arb #(
      .T ( xbar_pkg::payload_t )
    ) i_rr_arb (
      .clk_i    ( clk_i        ),
      .arst_n_i ( arst_n_i     ),
      .req_i    ( out_valid[j] ),
      .gnt_o    ( out_ready[j] ),
      .data_i   ( data_i       ),
      .oup      ( arb_if.src   )
    );

    spill_register #(
      .T ( xbar_pkg::payload_t )
    ) i_spill_register (
      .clk_i       ( clk_i      ),
      .arst_n_i    ( arst_n_i   ),
      .inp         ( arb_if.dst ),
      .oup_valid_o ( valid_o[j] ),
      .oup_ready_i ( ready_i[j] ),
      .oup_data_o  ( data_o[j]  ),
      .oup_idx_o   ( idx_o[j]   )
    );
  end

endmodule

// ==== stream_xbar_top.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

// Top level of the stream crossbar.
// It exposes the core with plain packed-array ports, one entry per input
// on the upstream side and one entry per output on the downstream side.
// The sizes come from the shared header.
module stream_xbar_top (
  // Clock, rising edge.
  input  logic                                    clk_i,
  // Asynchronous reset, active low.
  input  logic                                    arst_n_i,
  // Data word per input, held while valid is high.
  input  xbar_pkg::payload_t [`XBAR_NUM_INP-1:0] data_i,
  // Target output per input, held while valid is high.
  input  xbar_pkg::sel_t     [`XBAR_NUM_INP-1:0] sel_i,
  // Input has an item.
  input  logic               [`XBAR_NUM_INP-1:0] valid_i,
  // Input item is taken on this edge.
  output logic               [`XBAR_NUM_INP-1:0] ready_o,
  // Data word per output.
  output xbar_pkg::payload_t [`XBAR_NUM_OUT-1:0] data_o,
  // Source input of each output word.
  output xbar_pkg::idx_t     [`XBAR_NUM_OUT-1:0] idx_o,
  // Output has an item.
  output logic               [`XBAR_NUM_OUT-1:0] valid_o,
  // Downstream takes the output item.
  input  logic               [`XBAR_NUM_OUT-1:0] ready_i
);

  // The crossbar core.
  stream_xbar i_stream_xbar (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .data_i   ( data_i   ),
    .sel_i    ( sel_i    ),
    .valid_i  ( valid_i  ),
    .ready_o  ( ready_o  ),
    .data_o   ( data_o   ),
    .idx_o    ( idx_o    ),
    .valid_o  ( valid_o  ),
    .ready_i  ( ready_i  )
  );

endmodule

// ==== tb_stream_xbar_top.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

// Directed testbench for the stream crossbar top level.
// A driver feeds per-input stimulus lists 2 ns after each rising edge.
// A monitor samples at the falling edge, where all signals are settled.
// The monitor runs a model of each output. The model holds the round-robin
// pointer, the lock and the occupancy of the two-entry output stage.
// It predicts every input ready and every delivered word in order.
module tb_stream_xbar_top;

  localparam int N_INP = `XBAR_NUM_INP;
  localparam int N_OUT = `XBAR_NUM_OUT;
  localparam int DEPTH = 1024;
  // Rough length of each test in cycles.
  // The watchdog allows four times their sum plus some slack.
  localparam int LEN_PAIRS = 100;
  localparam int LEN_RR    = 30;
  localparam int LEN_BP    = 60;
  localparam int LEN_INDEP = 50;
  localparam int LEN_RAND  = 700;
  localparam int TIMEOUT_CYCLES =
    4 * (LEN_PAIRS + LEN_RR + LEN_BP + LEN_INDEP + LEN_RAND) + 200;

  logic                           clk_i;
  logic                           arst_n_i;
  xbar_pkg::payload_t [N_INP-1:0] data_i;
  xbar_pkg::sel_t     [N_INP-1:0] sel_i;
  logic               [N_INP-1:0] valid_i;
  logic               [N_INP-1:0] ready_o;
  xbar_pkg::payload_t [N_OUT-1:0] data_o;
  xbar_pkg::idx_t     [N_OUT-1:0] idx_o;
  logic               [N_OUT-1:0] valid_o;
  logic               [N_OUT-1:0] ready_i;

  // Items still to be sent with one list per input.
  xbar_pkg::payload_t stim_data [N_INP][DEPTH];
  xbar_pkg::sel_t     stim_sel [N_INP][DEPTH];
  int                 stim_wr [N_INP];
  int                 stim_rd [N_INP];
  // Set by the monitor when an input handshake happens on the next edge.
  logic [N_INP-1:0]   taken;

  // Words each output must still deliver in model order.
  xbar_pkg::payload_t exp_data [N_OUT][DEPTH];
  xbar_pkg::idx_t     exp_idx [N_OUT][DEPTH];
  int                 exp_wr [N_OUT];
  int                 exp_rd [N_OUT];
  // Input handshakes the DUT made toward each output.
  int                 accepted [N_OUT];
  int                 delivered [N_OUT];

  // Output model state with pointer, lock and number of buffered items.
  int                 ptr_m [N_OUT];
  logic               lock_m [N_OUT];
  int                 lock_idx_m [N_OUT];
  int                 cnt_m [N_OUT];

  // Output word seen while stalled in the previous cycle.
  logic               stall_q [N_OUT];
  xbar_pkg::payload_t held_data [N_OUT];
  xbar_pkg::idx_t     held_idx [N_OUT];

  logic [N_OUT-1:0]   ready_cfg;
  logic               rand_ready;
  logic [N_OUT-1:0]   ready_pat [DEPTH];
  int                 pat_pos;
  int                 log_out;
  int                 log_cnt;
  xbar_pkg::idx_t     idx_log [16];
  int                 check_cnt;
  int                 err_cnt;
  int                 cycles;

  stream_xbar_top dut_i (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .data_i   ( data_i   ),
    .sel_i    ( sel_i    ),
    .valid_i  ( valid_i  ),
    .ready_o  ( ready_o  ),
    .data_o   ( data_o   ),
    .idx_o    ( idx_o    ),
    .valid_o  ( valid_o  ),
    .ready_i  ( ready_i  )
  );

  // 20 ns clock period.
  always #10 clk_i = ~clk_i;

  task automatic check_data(input string name, input xbar_pkg::payload_t exp,
                            input xbar_pkg::payload_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input xbar_pkg::idx_t exp,
                           input xbar_pkg::idx_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic print_counts();
    $display("Summary: %0d checks run, %0d errors", check_cnt, err_cnt);
  endtask

  // Queue one item on an input. The driver sends it when the input is free.
  task automatic push_item(input int inp, input int oup, input xbar_pkg::payload_t data);
    stim_sel[inp][stim_wr[inp]]  = xbar_pkg::sel_t'(oup);
    stim_data[inp][stim_wr[inp]] = data;
    stim_wr[inp]++;
  endtask

  // Nothing left to send and every accepted word has come out.
  function automatic logic is_idle();
    logic idle;
    idle = (valid_i == '0);
    for (int i = 0; i < N_INP; i++) begin
      if (stim_rd[i] != stim_wr[i]) idle = 1'b0;
    end
    for (int j = 0; j < N_OUT; j++) begin
      if (exp_rd[j] != exp_wr[j]) idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic wait_idle();
    do @(posedge clk_i); while (!is_idle());
  endtask

  // Input driver. Holds valid, data and select until the handshake.
  always @(posedge clk_i) begin : drive_inputs
    #2;
    if (arst_n_i) begin
      for (int i = 0; i < N_INP; i++) begin
        if (valid_i[i] && taken[i]) begin
          valid_i[i] = 1'b0;
          taken[i]   = 1'b0;
        end
        if (!valid_i[i] && stim_rd[i] < stim_wr[i]) begin
          sel_i[i]   = stim_sel[i][stim_rd[i]];
          data_i[i]  = stim_data[i][stim_rd[i]];
          valid_i[i] = 1'b1;
          stim_rd[i]++;
        end
      end
      if (rand_ready) begin
        ready_i = ready_pat[pat_pos % DEPTH];
        pat_pos++;
      end else begin
        ready_i = ready_cfg;
      end
    end
  end

  // Monitor and output model sample in the middle of the cycle.
  always @(negedge clk_i) begin : monitor
    int               win [N_OUT];
    logic             space [N_OUT];
    logic             pop [N_OUT];
    logic [N_INP-1:0] req;
    int               cand;
    logic             found;
    int               s;
    if (arst_n_i) begin
      // The output side is checked first against the occupancy before this edge.
      for (int j = 0; j < N_OUT; j++) begin
        pop[j] = 1'b0;
        check_bit($sformatf("valid_o[%0d]", j), cnt_m[j] > 0, valid_o[j]);
        if (stall_q[j]) begin
          check_data($sformatf("stalled data_o[%0d]", j), held_data[j], data_o[j]);
          check_idx($sformatf("stalled idx_o[%0d]", j), held_idx[j], idx_o[j]);
        end
        if (valid_o[j] && ready_i[j]) begin
          pop[j] = 1'b1;
          delivered[j]++;
          if (j == log_out && log_cnt < 16) begin
            idx_log[log_cnt] = idx_o[j];
            log_cnt++;
          end
          if (exp_rd[j] == exp_wr[j]) begin
            report_error($sformatf("output %0d delivered a word nobody sent", j));
          end else begin
            check_data($sformatf("data_o[%0d]", j), exp_data[j][exp_rd[j]], data_o[j]);
            check_idx($sformatf("idx_o[%0d]", j), exp_idx[j][exp_rd[j]], idx_o[j]);
            exp_rd[j]++;
          end
        end
        stall_q[j]   = valid_o[j] && !ready_i[j];
        held_data[j] = data_o[j];
        held_idx[j]  = idx_o[j];
      end
      // Arbitration. The stage has room while it holds fewer than two items.
      for (int j = 0; j < N_OUT; j++) begin
        req = '0;
        for (int i = 0; i < N_INP; i++) begin
          if (valid_i[i] && int'(sel_i[i]) == j) req[i] = 1'b1;
        end
        space[j] = cnt_m[j] < 2;
        win[j]   = lock_m[j] ? lock_idx_m[j] : ptr_m[j];
        found    = lock_m[j];
        for (int off = 0; off < N_INP; off++) begin
          cand = (ptr_m[j] + off) % N_INP;
          if (!found && req[cand]) begin
            found  = 1'b1;
            win[j] = cand;
          end
        end
        if (req != '0 && space[j]) begin
          exp_data[j][exp_wr[j]] = data_i[win[j]];
          exp_idx[j][exp_wr[j]]  = xbar_pkg::idx_t'(win[j]);
          exp_wr[j]++;
          cnt_m[j]++;
          ptr_m[j]  = (win[j] + 1) % N_INP;
          lock_m[j] = 1'b0;
        end else if (req != '0) begin
          lock_m[j]     = 1'b1;
          lock_idx_m[j] = win[j];
        end
        if (pop[j] && cnt_m[j] > 0) cnt_m[j]--;
      end
      // Each input is granted only as the winner of an output with room.
      for (int i = 0; i < N_INP; i++) begin
        s = int'(sel_i[i]);
        check_bit($sformatf("ready_o[%0d]", i),
                  valid_i[i] && win[s] == i && space[s], ready_o[i]);
        taken[i] = valid_i[i] && ready_o[i];
        if (taken[i]) accepted[s]++;
      end
    end
  end

  // Every input-to-output pair gets one item at a time, and each arrives one cycle late.
  task automatic reset_and_pairs();
    @(negedge clk_i);
    for (int j = 0; j < N_OUT; j++) begin
      check_bit($sformatf("valid_o[%0d] after reset", j), 1'b0, valid_o[j]);
    end
    @(posedge clk_i);
    for (int i = 0; i < N_INP; i++) begin
      for (int j = 0; j < N_OUT; j++) begin
        push_item(i, j, xbar_pkg::payload_t'($urandom));
        wait_idle();
      end
    end
  endtask

  // The last pair test left every pointer at input 0.
  task automatic round_robin_order();
    log_out = 2;
    log_cnt = 0;
    for (int i = 0; i < N_INP; i++) begin
      push_item(i, 2, xbar_pkg::payload_t'($urandom));
      push_item(i, 2, xbar_pkg::payload_t'($urandom));
    end
    wait_idle();
    log_out = -1;
    if (log_cnt != 2 * N_INP) report_error("output 2 did not deliver all eight words");
    for (int k = 0; k < log_cnt; k++) begin
      check_idx($sformatf("idx_o[2] word %0d", k), xbar_pkg::idx_t'(k % N_INP), idx_log[k]);
    end
  endtask

  task automatic back_pressure_lock();
    int acc0;
    acc0 = accepted[1];
    ready_cfg[1] = 1'b0;
    for (int i = 0; i < N_INP; i++) begin
      push_item(i, 1, xbar_pkg::payload_t'($urandom));
      push_item(i, 1, xbar_pkg::payload_t'($urandom));
    end
    repeat (12) @(posedge clk_i);
    if (accepted[1] - acc0 != 2) begin
      report_error($sformatf("stalled output 1 took %0d items, not two", accepted[1] - acc0));
    end
    ready_cfg[1] = 1'b1;
    wait_idle();
  endtask

  task automatic independent_outputs();
    logic done;
    ready_cfg[0] = 1'b0;
    for (int n = 0; n < 3; n++) push_item(0, 0, xbar_pkg::payload_t'($urandom));
    for (int i = 1; i < N_INP; i++) begin
      push_item(i, i, xbar_pkg::payload_t'($urandom));
      push_item(i, i, xbar_pkg::payload_t'($urandom));
    end
    do begin
      @(posedge clk_i);
      done = 1'b1;
      for (int i = 1; i < N_INP; i++) begin
        if (stim_rd[i] != stim_wr[i] || valid_i[i] || exp_rd[i] != exp_wr[i]) done = 1'b0;
      end
    end while (!done);
    @(negedge clk_i);
    check_bit("valid_o[0] while stalled", 1'b1, valid_o[0]);
    @(posedge clk_i);
    ready_cfg[0] = 1'b1;
    wait_idle();
  endtask

  task automatic random_traffic();
    int del0;
    del0 = 0;
    for (int j = 0; j < N_OUT; j++) del0 += delivered[j];
    for (int k = 0; k < DEPTH; k++) ready_pat[k] = N_OUT'($urandom);
    for (int n = 0; n < 300; n++) begin
      push_item($urandom % N_INP, $urandom % N_OUT, xbar_pkg::payload_t'($urandom));
    end
    rand_ready = 1'b1;
    wait_idle();
    rand_ready = 1'b0;
    for (int j = 0; j < N_OUT; j++) del0 -= delivered[j];
    if (del0 != -300) report_error($sformatf("random test delivered %0d words, not 300", -del0));
  endtask

  // Watchdog.
  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      err_cnt++;
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(81));
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    data_i     = '0;
    sel_i      = '0;
    valid_i    = '0;
    ready_i    = '1;
    ready_cfg  = '1;
    rand_ready = 1'b0;
    taken      = '0;
    pat_pos    = 0;
    log_out    = -1;
    log_cnt    = 0;
    check_cnt  = 0;
    err_cnt    = 0;
    cycles     = 0;
    for (int i = 0; i < N_INP; i++) begin
      stim_wr[i] = 0;
      stim_rd[i] = 0;
    end
    for (int j = 0; j < N_OUT; j++) begin
      exp_wr[j]     = 0;
      exp_rd[j]     = 0;
      accepted[j]   = 0;
      delivered[j]  = 0;
      ptr_m[j]      = 0;
      lock_m[j]     = 1'b0;
      lock_idx_m[j] = 0;
      cnt_m[j]      = 0;
      stall_q[j]    = 1'b0;
    end
    // Hold reset for three cycles and release it off the clock edge.
    repeat (3) @(posedge clk_i);
    #2 arst_n_i = 1'b1;
    @(posedge clk_i);
    reset_and_pairs();
    round_robin_order();
    back_pressure_lock();
    independent_outputs();
    random_traffic();
    print_counts();
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== stream_xbar_top.f ====
+incdir+.
xbar_pkg.sv
stream_if.sv
stream_demux.sv
rr_arb.sv
spill_register.sv
stream_xbar.sv
stream_xbar_top.sv
tb_stream_xbar_top.sv
